/* filelist.f */
+incdir+src
src/agc_loop_pkg.sv
src/scale_update.sv
src/offset_update.sv
src/agc_loop_sequencer.sv
src/status_target.sv
src/agc_loop_top.sv
testbench/tb_clock_gen.sv
testbench/agc_loop_assertions.sv
testbench/agc_loop_tb.sv

/* Makefile */
TOP = agc_loop_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing --assert -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* testbench/agc_loop_tb.sv */
`timescale 1ns/1ps
`include "agc_loop_macros.svh"

module agc_loop_tb;

    localparam int          ROWS      = 9;
    localparam int unsigned SEED      = 32'hf39d_02d0;
    localparam logic [31:0] DONE_WORD = 32'h0000_0002;  // Status with bit 1 set
    localparam logic [31:0] CMD_START = 32'h0000_0001;
    localparam logic [31:0] CMD_RESET = 32'h0000_0004;
    localparam logic [31:0] CMD_LOAD  = 32'h0000_0300;
    localparam logic [31:0] CMD_APPLY = 32'h0000_0400;

    typedef struct packed {
        logic [31:0] ms_acc;
        logic [31:0] cnt_above;
        logic [31:0] cnt_below;
        logic [31:0] scale;     // Written in the following pass
        logic [31:0] offset;
    } row_t;

    logic                   wb_clk;
    logic                   reset;
    agc_loop_pkg::bus_req_t host_req;
    logic                   host_ack;
    logic [31:0]            host_dat;
    agc_loop_pkg::bus_req_t agc_req;
    logic                   agc_ack;
    logic [31:0]            agc_dat;

    row_t        stim [ROWS];
    logic [31:0] stored_scale;      // Downstream block registers
    logic [31:0] stored_offset;
    logic [31:0] exp_scale;
    logic [31:0] exp_offset;
    int          errors;
    int          checks;
    int          row_errors;
    int          total_fails;

    tb_clock_gen u_clock (.wb_clk_o(wb_clk), .reset_o(reset));

    agc_loop_top uut (
        .wb_clk_i   (wb_clk),
        .reset_i    (reset),
        .host_req_i (host_req),
        .host_ack_o (host_ack),
        .host_dat_o (host_dat),
        .agc_req_o  (agc_req),
        .agc_ack_i  (agc_ack),
        .agc_dat_i  (agc_dat)
    );

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            $display("error %0t ns: %s got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Downstream AGC model, one transfer
    task automatic serve_transfer(input logic we, input logic [7:0] adr,
                                  input logic [31:0] dat, input logic [31:0] rsp,
                                  input string what);
        int unsigned delay;
        while (!agc_req.cyc) @(negedge wb_clk);
        checks++;
        assert (agc_req.we === we && agc_req.adr === adr && (!we || agc_req.dat === dat))
        else begin
            $display("error %0t ns: %s got we %0b adr %h dat %h, expected we %0b adr %h dat %h",
                     $time, what, agc_req.we, agc_req.adr, agc_req.dat, we, adr, dat);
            errors++;
        end
        if (agc_req.we && agc_req.adr == `AGC_ADDR_SCALE) stored_scale = agc_req.dat;
        if (agc_req.we && agc_req.adr == `AGC_ADDR_OFFSET) stored_offset = agc_req.dat;
        delay = $urandom % 4;                   // 0 to 3 cycles of back-pressure
        repeat (delay) @(negedge wb_clk);
        agc_ack = 1'b1;
        agc_dat = rsp;
        @(negedge wb_clk);
        agc_ack = 1'b0;
        agc_dat = '0;
    endtask

    task automatic host_read(input logic [7:0] adr, input logic [31:0] exp, input string what);
        int          wait_cycles;
        logic [31:0] got;
        host_req    = {1'b1, 1'b0, adr, 32'd0};
        wait_cycles = 1;                        // Target samples the request in this IDLE cycle
        do begin
            @(negedge wb_clk);
            wait_cycles++;
        end while (!host_ack);
        got      = host_dat;
        host_req = '0;                          // Drop cyc with the ack
        check_value(got, exp, what);
        checks++;
        assert (wait_cycles == 3) else begin
            $display("error %0t ns: %s acked after %0d cycles, expected 3",
                     $time, what, wait_cycles);
            errors++;
        end
        @(negedge wb_clk);
    endtask

    function automatic logic [31:0] info_word(input int row, input int idx);
        case (idx)
            0: return DONE_WORD;
            1: return stim[row].ms_acc;
            2: return stim[row].cnt_above;
            3: return stim[row].cnt_below;
            4: return stored_scale;
            default: return stored_offset;
        endcase
    endfunction

    ////////////////////////////////////////
    // Main sequence
    initial begin
        void'($urandom(SEED));
        host_req      = '0;
        agc_ack       = 1'b0;
        agc_dat       = '0;
        stored_scale  = '0;
        stored_offset = '0;
        errors        = 0;
        checks        = 0;
        //          ms word       above   below   scale     offset
        stim[0] = '{32'h0002_8000, 32'd50,  32'd10,  32'd1770, 32'hffff_ffe7};
        stim[1] = '{32'h0001_0000, 32'd10,  32'd40,  32'd1800, 32'h0000_0000};
        stim[2] = '{32'h0002_0000, 32'd20,  32'd22,  32'd1800, 32'h0000_0000};  // Both dead band
        stim[3] = '{32'h000c_8000, 32'd30,  32'd35,  32'd1770, 32'h0000_0000};
        stim[4] = '{32'h0000_6000, 32'd41,  32'd35,  32'd1800, 32'hffff_ffe7};
        stim[5] = '{32'h0002_1fff, 32'd0,   32'd100, 32'd1800, 32'h0000_0000};  // Low bits dropped
        stim[6] = '{32'h0002_2000, 32'd100, 32'd0,   32'd1770, 32'hffff_ffe7};
        stim[7] = '{32'h0001_e000, 32'd5,   32'd0,   32'd1800, 32'hffff_ffe7};
        stim[8] = '{32'hfe02_0000, 32'd7,   32'd20,  32'd1800, 32'h0000_0000};  // High bits dropped
        @(posedge wb_clk);
        while (reset) @(posedge wb_clk);
        @(negedge wb_clk);
        repeat (`AGC_BOOT_CYCLES) begin
            checks++;
            assert (!agc_req.cyc && !host_ack) else begin
                $display("error %0t ns: bus active during the boot delay", $time);
                errors++;
            end
            @(negedge wb_clk);
        end
        exp_scale  = `AGC_START_SCALE;
        exp_offset = `AGC_START_OFFSET;
        serve_transfer(1'b1, `AGC_ADDR_SCALE, exp_scale, '0, "start scale write");
        serve_transfer(1'b1, `AGC_ADDR_OFFSET, exp_offset, '0, "start offset write");
        $display("boot delay and start values: %s", (errors == 0) ? "ok" : "FAILED");
        for (int i = 0; i < ROWS; i++) begin
            row_errors = errors;
            serve_transfer(1'b1, `AGC_ADDR_CTRL, CMD_LOAD, '0, "load command");
            serve_transfer(1'b1, `AGC_ADDR_CTRL, CMD_APPLY, '0, "apply command");
            serve_transfer(1'b1, `AGC_ADDR_CTRL, CMD_RESET, '0, "stats reset command");
            serve_transfer(1'b1, `AGC_ADDR_CTRL, CMD_START, '0, "start command");
            for (int p = 1; p <= 3; p++) begin
                serve_transfer(1'b0, `AGC_ADDR_CTRL, '0, (p == 3) ? DONE_WORD : '0,
                               "status poll");
            end
            for (int w = 0; w < `AGC_INFO_WORDS; w++) begin
                serve_transfer(1'b0, 8'(w * 4), '0, info_word(i, w), "info read");
            end
            // Next scale write is held off while the host reads back
            host_read(8'h04, stim[i].ms_acc, "host mean square");
            host_read(8'h08, stim[i].cnt_above, "host count above");
            host_read(8'h0c, stim[i].cnt_below, "host count below");
            host_read(8'h10, exp_scale, "host scale");
            host_read(8'h14, exp_offset, "host offset");
            host_read(8'h40, 32'd30, "host scale step");
            host_read(8'h44, 32'd25, "host offset step");
            serve_transfer(1'b1, `AGC_ADDR_SCALE, stim[i].scale, '0, "scale write");
            serve_transfer(1'b1, `AGC_ADDR_OFFSET, stim[i].offset, '0, "offset write");
            exp_scale  = stim[i].scale;
            exp_offset = stim[i].offset;
            $display("row %0d: ms %h above %0d below %0d, scale %0d offset %0d, %s", i,
                     stim[i].ms_acc, stim[i].cnt_above, stim[i].cnt_below, stim[i].scale,
                     $signed(stim[i].offset), (errors == row_errors) ? "ok" : "FAILED");
        end
        total_fails = errors + int'(uut.u_assertions.fail_count);
        $display("checks %0d, failed %0d, assertion failures %0d", checks, errors,
                 uut.u_assertions.fail_count);
        if (total_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog, 400 cycles per row
    initial begin
        repeat (ROWS * 400) @(posedge wb_clk);
        $display("Timeout: the loop made no progress within %0d cycles", ROWS * 400);
        $display("Test failures found");
        $finish;
    end

endmodule

/* testbench/agc_loop_assertions.sv */
`timescale 1ns/1ps

module agc_loop_assertions (
    input logic                   wb_clk_i,
    input logic                   reset_i,
    input agc_loop_pkg::bus_req_t agc_req_i,
    input logic                   agc_ack_i,
    input logic                   host_ack_i
);

    int unsigned fail_count = 0;    // Summed into the testbench totals

    // Request held while the master waits for ack
    req_held: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (agc_req_i.cyc && !agc_ack_i) |=> $stable(agc_req_i))
        else begin
            $error("downstream request changed before ack");
            fail_count++;
        end

    host_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        host_ack_i |=> !host_ack_i)
        else begin
            $error("host ack held longer than one cycle");
            fail_count++;
        end

    // Master leaves a gap after every transfer
    cyc_gap: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (agc_req_i.cyc && agc_ack_i) |=> !agc_req_i.cyc)
        else begin
            $error("cyc still high in the cycle after ack");
            fail_count++;
        end

endmodule

bind agc_loop_top agc_loop_assertions u_assertions (
    .wb_clk_i   (wb_clk_i),
    .reset_i    (reset_i),
    .agc_req_i  (agc_req_o),
    .agc_ack_i  (agc_ack_i),
    .host_ack_i (host_ack_o)
);

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic wb_clk_o,
    output logic reset_o
);

    initial begin
        wb_clk_o = 1'b0;
        forever #5 wb_clk_o = ~wb_clk_o;    // 10 ns period
    end

    // Reset spans 16 rising edges, released on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (16) @(negedge wb_clk_o);
        reset_o = 1'b0;
    end

endmodule

/* src/agc_loop_top.sv */
`timescale 1ns/1ps

module agc_loop_top (
    input  logic                   wb_clk_i,
    input  logic                   reset_i,
    input  agc_loop_pkg::bus_req_t host_req_i,
    output logic                   host_ack_o,
    output logic [31:0]            host_dat_o,
    output agc_loop_pkg::bus_req_t agc_req_o,
    input  logic                   agc_ack_i,
    input  logic [31:0]            agc_dat_i
);

    agc_loop_pkg::agc_info_t info;
    logic                    calc;
    logic [16:0]             new_scale;
    logic [15:0]             new_offset;

    ////////////////////////////////////////
    // Downstream master
    agc_loop_sequencer u_sequencer (
        .wb_clk_i     (wb_clk_i),
        .reset_i      (reset_i),
        .agc_ack_i    (agc_ack_i),
        .agc_dat_i    (agc_dat_i),
        .new_scale_i  (new_scale),
        .new_offset_i (new_offset),
        .agc_req_o    (agc_req_o),
        .info_o       (info),
        .calc_o       (calc)
    );

    // Scale and offset work side by side
    scale_update u_scale (
        .wb_clk_i    (wb_clk_i),
        .reset_i     (reset_i),
        .calc_i      (calc),
        .info_i      (info),
        .new_scale_o (new_scale)
    );

    offset_update u_offset (
        .wb_clk_i     (wb_clk_i),
        .reset_i      (reset_i),
        .calc_i       (calc),
        .info_i       (info),
        .new_offset_o (new_offset)
    );

    ////////////////////////////////////////
    // Host side
    status_target u_target (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .host_req_i (host_req_i),
        .info_i     (info),
        .host_ack_o (host_ack_o),
        .host_dat_o (host_dat_o)
    );

endmodule

/* src/status_target.sv */
`timescale 1ns/1ps
`include "agc_loop_macros.svh"

module status_target (
    input  logic                    wb_clk_i,
    input  logic                    reset_i,
    input  agc_loop_pkg::bus_req_t  host_req_i,
    input  agc_loop_pkg::agc_info_t info_i,
    output logic                    host_ack_o,
    output logic [31:0]             host_dat_o
);

    agc_loop_pkg::target_state_e state;
    logic [31:0]                 rsp_reg;
    logic [15:0]                 offset_delta;
    logic [3:0]                  sel;

    assign offset_delta = 16'(`AGC_OFFSET_DELTA);
    assign sel          = host_req_i.adr[5:2];

    // IDLE -> READ/WRITE -> ACK, writes are dropped
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state <= agc_loop_pkg::IDLE;
        end else begin
            case (state)
                agc_loop_pkg::IDLE: if (host_req_i.cyc) begin
                    state <= host_req_i.we ? agc_loop_pkg::WRITE : agc_loop_pkg::READ;
                end
                agc_loop_pkg::WRITE: state <= agc_loop_pkg::ACK;
                agc_loop_pkg::READ: state <= agc_loop_pkg::ACK;
                default: state <= agc_loop_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state == agc_loop_pkg::READ) begin
            if (host_req_i.adr[6]) begin                  // Step sizes
                if (sel == 4'd0) rsp_reg <= `AGC_SCALE_DELTA;
                else if (sel == 4'd1) rsp_reg <= {{16{offset_delta[15]}}, offset_delta};
            end else begin
                case (sel)
                    4'd0: rsp_reg <= info_i.status;
                    4'd1: rsp_reg <= info_i.ms_acc;
                    4'd2: rsp_reg <= info_i.cnt_above;
                    4'd3: rsp_reg <= info_i.cnt_below;
                    4'd4: rsp_reg <= info_i.scale;
                    4'd5: rsp_reg <= info_i.offset;
                    default: rsp_reg <= 32'd0;            // Unmapped word
                endcase
            end
        end
    end

    assign host_ack_o = (state == agc_loop_pkg::ACK);
    assign host_dat_o = rsp_reg;

endmodule

/* src/agc_loop_sequencer.sv */
`timescale 1ns/1ps
`include "agc_loop_macros.svh"

module agc_loop_sequencer (
    input  logic                    wb_clk_i,
    input  logic                    reset_i,
    input  logic                    agc_ack_i,
    input  logic [31:0]             agc_dat_i,
    input  logic [16:0]             new_scale_i,
    input  logic [15:0]             new_offset_i,
    output agc_loop_pkg::bus_req_t  agc_req_o,
    output agc_loop_pkg::agc_info_t info_o,
    output logic                    calc_o
);

    agc_loop_pkg::loop_state_e loop_state;
    agc_loop_pkg::comm_phase_e phase;
    agc_loop_pkg::bus_req_t    agc_req;
    agc_loop_pkg::bus_req_t    send_req;   // Request for the current loop state
    agc_loop_pkg::agc_info_t   info;
    logic [2:0]                info_idx;   // Info word, or scale/offset select in WRITING
    logic [4:0]                boot_cnt;
    logic [31:0]               agc_rsp;    // Last read data

    ////////////////////////////////////////
    // Request decode
    always_comb begin
        send_req     = '0;
        send_req.cyc = 1'b1;
        send_req.adr = `AGC_ADDR_CTRL;
        case (loop_state)
            agc_loop_pkg::WRITING: begin
                send_req.we = 1'b1;
                if (info_idx == 3'd0) begin
                    send_req.adr = `AGC_ADDR_SCALE;
                    send_req.dat = {15'd0, new_scale_i};
                end else begin
                    send_req.adr = `AGC_ADDR_OFFSET;
                    send_req.dat = {{16{new_offset_i[15]}}, new_offset_i};
                end
            end
            agc_loop_pkg::LOADING: begin
                send_req.we  = 1'b1;
                send_req.dat = agc_loop_pkg::CMD_LOAD;
            end
            agc_loop_pkg::APPLYING: begin
                send_req.we  = 1'b1;
                send_req.dat = agc_loop_pkg::CMD_APPLY;
            end
            agc_loop_pkg::RESETTING: begin
                send_req.we  = 1'b1;
                send_req.dat = agc_loop_pkg::CMD_RESET_STATS;
            end
            agc_loop_pkg::POLLING: begin
                send_req.we  = 1'b1;
                send_req.dat = agc_loop_pkg::CMD_START;
            end
            agc_loop_pkg::WAITING: ;                             // Status poll
            agc_loop_pkg::READING: send_req.adr = {3'd0, info_idx, 2'b00};
            default: send_req.cyc = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Loop FSM
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            loop_state <= agc_loop_pkg::BOOT_DELAY;
            phase      <= agc_loop_pkg::SENDING;
            agc_req    <= '0;
            info       <= '0;
            info_idx   <= 3'd0;
            boot_cnt   <= 5'(`AGC_BOOT_CYCLES);
        end else if (loop_state == agc_loop_pkg::BOOT_DELAY) begin
            if (boot_cnt != 5'd0) boot_cnt <= boot_cnt - 5'd1;
            else loop_state <= agc_loop_pkg::WRITING;
        end else if (loop_state == agc_loop_pkg::CALCULATING) begin
            loop_state <= agc_loop_pkg::WRITING;  // Update modules latch this cycle
        end else begin
            case (phase)
                agc_loop_pkg::SENDING: begin
                    agc_req <= send_req;
                    phase   <= agc_loop_pkg::AWAITING_ACK;
                end
                agc_loop_pkg::AWAITING_ACK: if (agc_ack_i) begin
                    agc_req <= '0;                 // cyc drops on the ack edge
                    agc_rsp <= agc_dat_i;
                    phase   <= agc_req.we ? agc_loop_pkg::SENDING : agc_loop_pkg::PROCESSING;
                    case (loop_state)
                        agc_loop_pkg::WRITING: begin
                            if (info_idx == 3'd0) begin
                                info_idx <= 3'd1;
                            end else begin
                                info_idx   <= 3'd0;
                                loop_state <= agc_loop_pkg::LOADING;
                            end
                        end
                        agc_loop_pkg::LOADING: loop_state <= agc_loop_pkg::APPLYING;
                        agc_loop_pkg::APPLYING: begin
                            loop_state  <= agc_loop_pkg::RESETTING;
                            info.scale  <= {15'd0, new_scale_i};
                            info.offset <= {{16{new_offset_i[15]}}, new_offset_i};
                        end
                        agc_loop_pkg::RESETTING: loop_state <= agc_loop_pkg::POLLING;
                        agc_loop_pkg::POLLING: loop_state <= agc_loop_pkg::WAITING;
                        default: ;                 // Reads finish in PROCESSING
                    endcase
                end
                default: begin
                    phase <= agc_loop_pkg::SENDING;
                    if (loop_state == agc_loop_pkg::WAITING) begin
                        if (agc_rsp[`AGC_STATUS_DONE_BIT]) begin
                            loop_state <= agc_loop_pkg::READING;
                            info_idx   <= 3'd0;
                        end
                    end else begin
                        case (info_idx)
                            3'd0: info.status <= agc_rsp;
                            3'd1: info.ms_acc <= agc_rsp;
                            3'd2: info.cnt_above <= agc_rsp;
                            3'd3: info.cnt_below <= agc_rsp;
                            3'd4: info.scale <= agc_rsp;
                            default: info.offset <= agc_rsp;
                        endcase
                        if (info_idx == 3'(`AGC_INFO_WORDS - 1)) begin
                            info_idx   <= 3'd0;
                            loop_state <= agc_loop_pkg::CALCULATING;
                        end else begin
                            info_idx <= info_idx + 3'd1;
                        end
                    end
                end
            endcase
        end
    end

    assign agc_req_o = agc_req;
    assign info_o    = info;
    assign calc_o    = (loop_state == agc_loop_pkg::CALCULATING);  // One cycle wide

endmodule

/* src/offset_update.sv */
`timescale 1ns/1ps
`include "agc_loop_macros.svh"

module offset_update (
    input  logic                    wb_clk_i,
    input  logic                    reset_i,
    input  logic                    calc_i,
    input  agc_loop_pkg::agc_info_t info_i,
    output logic [15:0]             new_offset_o
);

    logic [31:0] above_limit;   // Count above must pass this to lower the offset
    logic [31:0] below_limit;
    logic [15:0] offset_delta;
    logic [15:0] offset_reg;

    assign above_limit  = info_i.cnt_below + `AGC_OFFSET_ERR;
    assign below_limit  = info_i.cnt_above + `AGC_OFFSET_ERR;
    assign offset_delta = 16'(`AGC_OFFSET_DELTA);

    // Wraps at 16 bits
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            offset_reg <= 16'(`AGC_START_OFFSET);
        end else if (calc_i) begin
            if (info_i.cnt_above > above_limit) begin
                offset_reg <= info_i.offset[15:0] - offset_delta;
            end else if (info_i.cnt_below > below_limit) begin
                offset_reg <= info_i.offset[15:0] + offset_delta;
            end
        end
    end

    assign new_offset_o = offset_reg;

endmodule

/* src/scale_update.sv */
`timescale 1ns/1ps
`include "agc_loop_macros.svh"

module scale_update (
    input  logic                    wb_clk_i,
    input  logic                    reset_i,
    input  logic                    calc_i,
    input  agc_loop_pkg::agc_info_t info_i,
    output logic [16:0]             new_scale_o
);

    logic [11:0] ms_adj;      // Mean square after timescale reduction
    logic [31:0] scale_down;
    logic [31:0] scale_up;
    logic [16:0] scale_reg;

    assign ms_adj     = info_i.ms_acc[24:17-`AGC_TIMESCALE_BITS];
    assign scale_down = info_i.scale - `AGC_SCALE_DELTA;
    assign scale_up   = info_i.scale + `AGC_SCALE_DELTA;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            scale_reg <= 17'(`AGC_START_SCALE);
        end else if (calc_i) begin
            if (ms_adj > `AGC_TARGET_RMS_SQ + `AGC_RMS_SQ_ERR) begin
                scale_reg <= scale_down[16:0];   // Too loud
            end else if (ms_adj < `AGC_TARGET_RMS_SQ - `AGC_RMS_SQ_ERR) begin
                scale_reg <= scale_up[16:0];     // Too quiet
            end
        end
    end

    assign new_scale_o = scale_reg;

endmodule

/* src/agc_loop_pkg.sv */
package agc_loop_pkg;

    // Bus request, cyc doubles as stb
    typedef struct packed {
        logic        cyc;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
    } bus_req_t;

    // Info words in downstream read order
    typedef struct packed {
        logic [31:0] status;
        logic [31:0] ms_acc;     // Mean-square accumulation
        logic [31:0] cnt_above;
        logic [31:0] cnt_below;
        logic [31:0] scale;
        logic [31:0] offset;
    } agc_info_t;

    typedef enum logic [31:0] {
        CMD_START       = 32'h0000_0001,
        CMD_RESET_STATS = 32'h0000_0004,
        CMD_LOAD        = 32'h0000_0300,
        CMD_APPLY       = 32'h0000_0400
    } agc_cmd_e;

    typedef enum logic [3:0] {
        BOOT_DELAY, RESETTING, POLLING, WAITING, READING,
        CALCULATING, WRITING, LOADING, APPLYING
    } loop_state_e;

    // Phase of a single downstream transfer
    typedef enum logic [1:0] {SENDING, AWAITING_ACK, PROCESSING} comm_phase_e;

    typedef enum logic [1:0] {IDLE, WRITE, READ, ACK} target_state_e;

endpackage

/* src/agc_loop_macros.svh */
`ifndef AGC_LOOP_MACROS_SVH
`define AGC_LOOP_MACROS_SVH

// Values written on the first pass
`define AGC_START_SCALE     32'd1800
`define AGC_START_OFFSET    32'd0

// Loop targets and dead bands
`define AGC_TARGET_RMS_SQ   32'd16
`define AGC_RMS_SQ_ERR      32'd0
`define AGC_OFFSET_ERR      32'd5

// Fixed step sizes
`define AGC_SCALE_DELTA     32'd30
`define AGC_OFFSET_DELTA    32'd25

`define AGC_TIMESCALE_BITS  32'd4   // Reduction of the mean-square word
`define AGC_BOOT_CYCLES     32'd31
`define AGC_INFO_WORDS      32'd6

// Downstream register map, 8-bit addresses
`define AGC_ADDR_CTRL       8'h00
`define AGC_ADDR_SCALE      8'h10
`define AGC_ADDR_OFFSET     8'h14

`define AGC_STATUS_DONE_BIT 1       // Sample cycle finished

`endif
